// File: common/spi_proto_pkg.sv
package spi_proto_pkg;

  // command word layout, write flag on top, then address, then data
  localparam int CMD_W  = 12;
  localparam int WR_BIT = 11;
  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;

  // a read address frame carries only the flag and the address
  localparam int RD_HDR_BITS = 4;

  // serial clock runs at clk / (2 * SCLK_HALF)
  localparam int SCLK_HALF = 5;

  // clocks with chip select high between the address and data frames of a read
  localparam int RD_GAP = 100;

  localparam int QUEUE_DEPTH = 4;

  // counter widths derived from the constants above
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int BIT_CNT_W   = $clog2(CMD_W + 1);
  localparam int GAP_CNT_W   = $clog2(RD_GAP);
  localparam int SCLK_CNT_W  = $clog2(SCLK_HALF);

endpackage

// File: common/spi_ctrl_pkg.sv
package spi_ctrl_pkg;

  // sequencer states of the SPI master
  typedef enum logic [3:0] {
    IDLE,
    LOAD,
    WR_SHIFT,
    RD_ADDR,
    RD_GAP,
    RD_SHIFT,
    RD_HOLD,
    FRAME_END
  } seq_state_t;

  // operation carried in the flag bit of a command
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_t;

endpackage

// File: src/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [spi_proto_pkg::CMD_W-1:0] in_data,
  input  logic                            in_valid,
  output logic                            in_ready,
  output logic [spi_proto_pkg::CMD_W-1:0] out_data,
  output logic                            out_valid,
  input  logic                            out_ready
);

  logic [spi_proto_pkg::CMD_W-1:0]       mem [spi_proto_pkg::QUEUE_DEPTH];
  logic [spi_proto_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [spi_proto_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [spi_proto_pkg::QUEUE_PTR_W:0]   count;
  logic                                  push;
  logic                                  pop;

  assign in_ready  = int'(count) != spi_proto_pkg::QUEUE_DEPTH;
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_data;
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: spi_master/sclk_gen.sv
`timescale 1ns/1ps

module sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic sclk_level,
  output logic launch,
  output logic sample
);

  logic [spi_proto_pkg::SCLK_CNT_W-1:0] half_cnt;
  logic                                 toggle;

  // the strobes lead the edge they belong to by one cycle so that
  // sampling and launching happen on the same clock as the sclk edge
  assign toggle = en && (int'(half_cnt) == spi_proto_pkg::SCLK_HALF - 1);
  assign sample = toggle && !sclk_level;
  assign launch = toggle && sclk_level;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt   <= '0;
      sclk_level <= 1'b0;
    end
    else if (!en)
    begin
      // restart phase aligned for the next frame
      half_cnt   <= '0;
      sclk_level <= 1'b0;
    end
    else if (toggle)
    begin
      half_cnt   <= '0;
      sclk_level <= ~sclk_level;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

// File: spi_master/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [spi_proto_pkg::CMD_W-1:0]  cmd_data,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  output logic [spi_proto_pkg::DATA_W-1:0] rd_data,
  output logic                             rd_valid,
  input  logic                             rd_ready,
  output logic                             sclk,
  output logic                             cs_n,
  output logic                             mosi,
  input  logic                             miso
);

  spi_ctrl_pkg::seq_state_t               state;
  spi_ctrl_pkg::cmd_op_t                  op;
  logic [spi_proto_pkg::CMD_W-1:0]        shift_buf;
  logic [spi_proto_pkg::DATA_W-1:0]       rx_shift;
  logic [spi_proto_pkg::BIT_CNT_W-1:0]    bit_cnt;
  logic [spi_proto_pkg::GAP_CNT_W-1:0]    gap_cnt;
  logic                                   sclk_en;
  logic                                   launch;
  logic                                   sample;
  logic                                   last_bit;
  logic                                   tx_shift;

  sclk_gen i_sclk_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (sclk_en),
    .sclk_level (sclk),
    .launch     (launch),
    .sample     (sample)
  );

  assign sclk_en = state inside {spi_ctrl_pkg::WR_SHIFT, spi_ctrl_pkg::RD_ADDR,
                                 spi_ctrl_pkg::RD_SHIFT};

  // pop straight from the queue only while idle
  assign cmd_ready = (state == spi_ctrl_pkg::IDLE) && cmd_valid;

  // the result is held in RD_HOLD, which also blocks the next pop
  assign rd_valid = (state == spi_ctrl_pkg::RD_HOLD);
  assign rd_data  = rx_shift;

  // frame length depends on which frame is running
  always_comb
  begin
    case (state)
      spi_ctrl_pkg::WR_SHIFT: last_bit = int'(bit_cnt) == spi_proto_pkg::CMD_W - 1;
      spi_ctrl_pkg::RD_ADDR:  last_bit = int'(bit_cnt) == spi_proto_pkg::RD_HDR_BITS - 1;
      spi_ctrl_pkg::RD_SHIFT: last_bit = int'(bit_cnt) == spi_proto_pkg::DATA_W - 1;
      default:                last_bit = 1'b0;
    endcase
  end

  // mosi moves to the next bit on every launch that is not the last one
  assign tx_shift = launch && !last_bit &&
                    (state == spi_ctrl_pkg::WR_SHIFT || state == spi_ctrl_pkg::RD_ADDR);

  always_ff @(posedge clk)
  begin
    if (cmd_valid && cmd_ready)
    begin
      shift_buf <= cmd_data;
    end
    else if (state == spi_ctrl_pkg::LOAD || tx_shift)
    begin
      shift_buf <= {shift_buf[spi_proto_pkg::CMD_W-2:0], 1'b0};
    end
  end

  // MSB first, sampled on the rising sclk edge
  always_ff @(posedge clk)
  begin
    if (state == spi_ctrl_pkg::RD_SHIFT && sample)
    begin
      rx_shift <= {rx_shift[spi_proto_pkg::DATA_W-2:0], miso};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= spi_ctrl_pkg::IDLE;
      op      <= spi_ctrl_pkg::OP_READ;
      bit_cnt <= '0;
      gap_cnt <= '0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      case (state)
        spi_ctrl_pkg::IDLE:
        begin
          if (cmd_valid)
          begin
            state <= spi_ctrl_pkg::LOAD;
          end
        end
        spi_ctrl_pkg::LOAD:
        begin
          op      <= spi_ctrl_pkg::cmd_op_t'(shift_buf[spi_proto_pkg::WR_BIT]);
          cs_n    <= 1'b0;
          mosi    <= shift_buf[spi_proto_pkg::CMD_W-1];
          bit_cnt <= '0;
          if (spi_ctrl_pkg::cmd_op_t'(shift_buf[spi_proto_pkg::WR_BIT]) ==
              spi_ctrl_pkg::OP_WRITE)
          begin
            state <= spi_ctrl_pkg::WR_SHIFT;
          end
          else
          begin
            state <= spi_ctrl_pkg::RD_ADDR;
          end
        end
        spi_ctrl_pkg::WR_SHIFT:
        begin
          if (launch && last_bit)
          begin
            cs_n  <= 1'b1;
            mosi  <= 1'b0;
            state <= spi_ctrl_pkg::FRAME_END;
          end
          else if (launch)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= shift_buf[spi_proto_pkg::CMD_W-1];
          end
        end
        spi_ctrl_pkg::RD_ADDR:
        begin
          if (launch && last_bit)
          begin
            cs_n    <= 1'b1;
            mosi    <= 1'b0;
            gap_cnt <= '0;
            state   <= spi_ctrl_pkg::RD_GAP;
          end
          else if (launch)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= shift_buf[spi_proto_pkg::CMD_W-1];
          end
        end
        spi_ctrl_pkg::RD_GAP:
        begin
          // turnaround for the peripheral, chip select stays high
          if (int'(gap_cnt) == spi_proto_pkg::RD_GAP - 1)
          begin
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            state   <= spi_ctrl_pkg::RD_SHIFT;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        spi_ctrl_pkg::RD_SHIFT:
        begin
          // the frame closes on the falling edge after the last sample
          if (launch && last_bit)
          begin
            cs_n  <= 1'b1;
            state <= spi_ctrl_pkg::FRAME_END;
          end
          else if (launch)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        spi_ctrl_pkg::FRAME_END:
        begin
          if (op == spi_ctrl_pkg::OP_READ)
          begin
            state <= spi_ctrl_pkg::RD_HOLD;
          end
          else
          begin
            state <= spi_ctrl_pkg::IDLE;
          end
        end
        spi_ctrl_pkg::RD_HOLD:
        begin
          if (rd_ready)
          begin
            state <= spi_ctrl_pkg::IDLE;
          end
        end
        default:
        begin
          state <= spi_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/spi_cmd_top.sv
`timescale 1ns/1ps

module spi_cmd_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [spi_proto_pkg::CMD_W-1:0]  cmd_data,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  output logic [spi_proto_pkg::DATA_W-1:0] rd_data,
  output logic                             rd_valid,
  input  logic                             rd_ready,
  output logic                             sclk,
  output logic                             cs_n,
  output logic                             mosi,
  input  logic                             miso
);

  logic [spi_proto_pkg::CMD_W-1:0] q_data;
  logic                            q_valid;
  logic                            q_ready;

  // the queue lets the host keep pushing while a frame is on the wire
  cmd_queue i_cmd_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (cmd_data),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_data  (q_data),
    .out_valid (q_valid),
    .out_ready (q_ready)
  );

  spi_master i_spi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_data  (q_data),
    .cmd_valid (q_valid),
    .cmd_ready (q_ready),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 100 ns period
  localparam time HALF_PERIOD = 50ns;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_PERIOD;
      clk = ~clk;
    end
  end

endmodule

// File: testbench/spi_device_model.sv
`timescale 1ns/1ps

module spi_device_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic proto_error,
  output int   wr_frames,
  output int   addr_frames,
  output int   rd_frames
);

  localparam int REG_COUNT = 2 ** spi_proto_pkg::ADDR_W;

  logic [spi_proto_pkg::DATA_W-1:0] regs [REG_COUNT];
  logic [spi_proto_pkg::CMD_W-1:0]  rx_bits;
  logic [spi_proto_pkg::DATA_W-1:0] tx_bits;
  logic [spi_proto_pkg::ADDR_W-1:0] rd_addr;
  logic                             rd_pending;
  int                               bit_count;

  task automatic report_error(input string msg);
    $display("device model error at time %0t: %s", $time, msg);
    proto_error = 1'b1;
  endtask

  // decode a finished frame from its length and its first bit
  task automatic finish_frame();
    if (rd_pending)
    begin
      if (bit_count != spi_proto_pkg::DATA_W)
        report_error($sformatf("read data frame had %0d bits instead of 8", bit_count));
      rd_pending = 1'b0;
      rd_frames++;
    end
    else if (bit_count == spi_proto_pkg::CMD_W && rx_bits[spi_proto_pkg::WR_BIT])
    begin
      regs[rx_bits[spi_proto_pkg::WR_BIT-1 -: spi_proto_pkg::ADDR_W]] =
        rx_bits[spi_proto_pkg::DATA_W-1:0];
      wr_frames++;
    end
    else if (bit_count == spi_proto_pkg::RD_HDR_BITS &&
             !rx_bits[spi_proto_pkg::RD_HDR_BITS-1])
    begin
      rd_addr    = rx_bits[spi_proto_pkg::ADDR_W-1:0];
      rd_pending = 1'b1;
      addr_frames++;
    end
    else if (bit_count == spi_proto_pkg::DATA_W)
      report_error("read data frame without a preceding address frame");
    else
      report_error($sformatf("frame of %0d bits matches no command", bit_count));
  endtask

  initial
  begin
    miso        = 1'b0;
    proto_error = 1'b0;
    wr_frames   = 0;
    addr_frames = 0;
    rd_frames   = 0;
    rd_pending  = 1'b0;
    rd_addr     = '0;
    tx_bits     = '0;
    for (int i = 0; i < REG_COUNT; i++)
      regs[i] = '0;
    forever
    begin
      @(negedge cs_n);
      bit_count = 0;
      rx_bits   = '0;
      if (rd_pending)
      begin
        tx_bits = regs[rd_addr];
        miso    = tx_bits[spi_proto_pkg::DATA_W-1];
      end
      // mode 0, mosi is taken on the rising edge and miso moves on the falling edge
      while (!cs_n)
      begin
        @(sclk or cs_n);
        if (!cs_n && sclk)
        begin
          rx_bits = {rx_bits[spi_proto_pkg::CMD_W-2:0], mosi};
          bit_count++;
        end
        else if (!cs_n && rd_pending)
        begin
          tx_bits = {tx_bits[spi_proto_pkg::DATA_W-2:0], 1'b0};
          miso    = tx_bits[spi_proto_pkg::DATA_W-1];
        end
      end
      miso = 1'b0;
      finish_frame();
    end
  end

endmodule

// File: testbench/tb_spi_cmd.sv
`timescale 1ns/1ps

module tb_spi_cmd;

  localparam int REG_COUNT    = 2 ** spi_proto_pkg::ADDR_W;
  localparam int RANDOM_COUNT = 40;
  localparam int HOLD_CYCLES  = 300;
  localparam int BIT_CYCLES   = 2 * spi_proto_pkg::SCLK_HALF;
  // a read is the longest command and a few cycles cover pop, load and release
  localparam int READ_CYCLES  = (spi_proto_pkg::RD_HDR_BITS + spi_proto_pkg::DATA_W) *
                                BIT_CYCLES + spi_proto_pkg::RD_GAP + 8;
  localparam int CMD_COUNT    = 2 + 2 * REG_COUNT + spi_proto_pkg::QUEUE_DEPTH + 2 +
                                REG_COUNT + 3 + RANDOM_COUNT;
  localparam int WATCHDOG_CYCLES = CMD_COUNT * READ_CYCLES + HOLD_CYCLES + 1000;

  logic                             clk;
  logic                             rst_n;
  logic [spi_proto_pkg::CMD_W-1:0]  cmd_data;
  logic                             cmd_valid;
  logic                             cmd_ready;
  logic [spi_proto_pkg::DATA_W-1:0] rd_data;
  logic                             rd_valid;
  logic                             rd_ready;
  logic                             sclk;
  logic                             cs_n;
  logic                             mosi;
  logic                             miso;
  logic                             model_error;
  int                               wr_frames;
  int                               addr_frames;
  int                               rd_frames;
  logic [spi_proto_pkg::DATA_W-1:0] exp_regs [REG_COUNT];
  logic [spi_proto_pkg::DATA_W-1:0] exp_reads [$];
  logic [31:0]                      lcg_state;

  tb_clock i_tb_clock (
    .clk (clk)
  );

  spi_cmd_top i_spi_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_device_model i_spi_device_model (
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .proto_error (model_error),
    .wr_frames   (wr_frames),
    .addr_frames (addr_frames),
    .rd_frames   (rd_frames)
  );

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_data(input string name, input logic [spi_proto_pkg::DATA_W-1:0] expected,
                              input logic [spi_proto_pkg::DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
      $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // every host task starts and ends on a falling clock edge
  task automatic push_cmd(input logic [spi_proto_pkg::CMD_W-1:0] cmd);
    cmd_data  = cmd;
    cmd_valid = 1'b1;
    while (!cmd_ready)
      @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic push_write(input logic [spi_proto_pkg::ADDR_W-1:0] addr,
                            input logic [spi_proto_pkg::DATA_W-1:0] data);
    exp_regs[addr] = data;
    push_cmd({spi_ctrl_pkg::OP_WRITE, addr, data});
  endtask

  task automatic push_read(input logic [spi_proto_pkg::ADDR_W-1:0] addr);
    exp_reads.push_back(exp_regs[addr]);
    push_cmd({spi_ctrl_pkg::OP_READ, addr, {spi_proto_pkg::DATA_W{1'b0}}});
  endtask

  task automatic collect_read();
    while (!rd_valid)
      @(negedge clk);
    if (exp_reads.size() == 0)
    begin
      $display("a read result arrived with no read command outstanding");
      abort_run();
    end
    compare_data("rd_data", exp_reads.pop_front(), rd_data);
    rd_ready = 1'b1;
    @(negedge clk);
    rd_ready = 1'b0;
  endtask

  task automatic read_all_registers();
    for (int a = 0; a < REG_COUNT; a++)
    begin
      push_read(a[spi_proto_pkg::ADDR_W-1:0]);
      collect_read();
    end
  endtask

  task automatic verify_reset_outputs();
    compare_bit("cmd_ready", 1'b1, cmd_ready);
    compare_bit("rd_valid", 1'b0, rd_valid);
    compare_bit("cs_n", 1'b1, cs_n);
    compare_bit("sclk", 1'b0, sclk);
    compare_bit("mosi", 1'b0, mosi);
  endtask

  task automatic write_then_read_back();
    int wr_before;
    int addr_before;
    int rd_before;
    wr_before   = wr_frames;
    addr_before = addr_frames;
    rd_before   = rd_frames;
    push_write(3'd5, 8'ha7);
    push_read(3'd5);
    collect_read();
    compare_count("model write frames", wr_before + 1, wr_frames);
    compare_count("model address frames", addr_before + 1, addr_frames);
    compare_count("model read data frames", rd_before + 1, rd_frames);
  endtask

  task automatic cover_all_addresses();
    logic [31:0] r;
    for (int a = 0; a < REG_COUNT; a++)
    begin
      r = lcg_next();
      // the address in the top bits keeps all eight values distinct
      push_write(a[spi_proto_pkg::ADDR_W-1:0], {a[2:0], r[20:16]});
    end
    read_all_registers();
  endtask

  task automatic overfill_queue();
    int a;
    logic [31:0] r;
    for (int i = 0; i < spi_proto_pkg::QUEUE_DEPTH + 2; i++)
    begin
      a = (i * 5 + 1) % REG_COUNT;
      r = lcg_next();
      push_write(a[spi_proto_pkg::ADDR_W-1:0], r[23:16]);
      // one command is on the wire and the queue holds the rest
      if (i == spi_proto_pkg::QUEUE_DEPTH)
        compare_bit("cmd_ready", 1'b0, cmd_ready);
    end
    read_all_registers();
  endtask

  task automatic stall_read_result();
    push_read(3'd2);
    push_write(3'd6, 8'h3c);
    push_read(3'd6);
    while (!rd_valid)
      @(negedge clk);
    repeat (HOLD_CYCLES)
    begin
      compare_bit("rd_valid", 1'b1, rd_valid);
      compare_data("rd_data", exp_reads[0], rd_data);
      compare_bit("cs_n", 1'b1, cs_n);
      @(negedge clk);
    end
    collect_read();
    collect_read();
  endtask

  task automatic random_command_mix();
    logic [31:0] r;
    spi_ctrl_pkg::cmd_op_t op;
    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      r  = lcg_next();
      op = spi_ctrl_pkg::cmd_op_t'(r[31]);
      if (op == spi_ctrl_pkg::OP_WRITE)
        push_write(r[30:28], r[23:16]);
      else
      begin
        push_read(r[30:28]);
        collect_read();
      end
    end
  endtask

  always @(posedge model_error)
  begin
    $display("the SPI device model saw a malformed frame");
    abort_run();
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial
  begin
    rst_n     = 1'b0;
    cmd_data  = '0;
    cmd_valid = 1'b0;
    rd_ready  = 1'b0;
    lcg_state = 32'd2906;
    for (int i = 0; i < REG_COUNT; i++)
      exp_regs[i] = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    verify_reset_outputs();
    write_then_read_back();
    cover_all_addresses();
    overfill_queue();
    stall_read_result();
    random_command_mix();
    if (exp_reads.size() == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("%0d read results never arrived", exp_reads.size());
      abort_run();
    end
  end

endmodule

// File: project.f
common/spi_proto_pkg.sv
common/spi_ctrl_pkg.sv
src/cmd_queue.sv
spi_master/sclk_gen.sv
spi_master/spi_master.sv
src/spi_cmd_top.sv
testbench/tb_clock.sv
testbench/spi_device_model.sv
testbench/tb_spi_cmd.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_spi_cmd \
  -f project.f -o tb_spi_cmd_sim &&
./obj_dir/tb_spi_cmd_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
